/* sv39_ptw.f */
+incdir+src
+incdir+verif
src/ptw_pkg.sv
src/ptw_if.sv
src/ptw_miss_arbiter.sv
src/ptw_walker.sv
src/ptw_pte_check.sv
src/sv39_ptw_top.sv
verif/ptw_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the sv39 walker testbench
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ptw_tb \
  -f sv39_ptw.f \
  -o Vptw_tb

# the simulation exits nonzero on $fatal, the log decides the result
./obj_dir/Vptw_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
exit 0

/* verif/ptw_tb_tasks.svh */
// --------------------
// walker directed tests
// table builders, walk drivers and checks
// --------------------

`ifndef PTW_TB_TASKS_SVH
`define PTW_TB_TASKS_SVH

int base_i;
int base_d;
int base_e;

function automatic int rand_below(input int n);
  int r;
  r = $random(seed) % n;
  if (r < 0) r = -r;
  return r;
endfunction

// PTE word built from reserved 0, ppn, rsw 0 and the flag byte
function automatic logic [63:0] pte_word(input logic [43:0] ppn, input logic [7:0] flags);
  return {10'b0, ppn, 2'b00, flags};
endfunction

// table base page joined with the VPN segment, times 8 bytes
function automatic logic [55:0] pte_addr(input logic [43:0] ppn, input logic [8:0] seg);
  return {ppn, seg, 3'b000};
endfunction

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
  assert (got === exp) else begin
    $display("FAIL %s got %h expected %h", name, got, exp);
    $display("RESULT: FAIL");
    $fatal(1, "value mismatch");
  end
endtask

task automatic check_reset_outputs();
  check_val("mem_req_o", mem_req_o, 0);
  check_val("ptw_active_o", ptw_active_o, 0);
  check_val("ptw_error_o", ptw_error_o, 0);
  check_val("itlb_update_o.valid", itlb_update_o.valid, 0);
  check_val("dtlb_update_o.valid", dtlb_update_o.valid, 0);
  check_val("itlb_miss_o", itlb_miss_o, 0);
  check_val("dtlb_miss_o", dtlb_miss_o, 0);
endtask

// root pointer, level 2 pointer, then the given leaf at level 3
task automatic build_3level(input logic [38:0] va, input logic [43:0] l2, input logic [43:0] l3,
                            input logic [63:0] leaf);
  pt_mem[pte_addr(satp_ppn_i, va[38:30])] = pte_word(l2, F_V);
  pt_mem[pte_addr(l2, va[29:21])]         = pte_word(l3, F_V);
  pt_mem[pte_addr(l3, va[20:12])]         = leaf;
endtask

task automatic mark_counts();
  base_i = itlb_upd_cnt;
  base_d = dtlb_upd_cnt;
  base_e = err_cnt;
endtask

// returns once an update or error was seen and the walker went inactive
task automatic wait_walk_end();
  while (itlb_upd_cnt + dtlb_upd_cnt + err_cnt == base_i + base_d + base_e) @(negedge clk_i);
  while (ptw_active_o) @(negedge clk_i);
endtask

task automatic expect_outcome(input int n_i, input int n_d, input int n_e);
  check_val("itlb_update_o pulses", itlb_upd_cnt - base_i, n_i);
  check_val("dtlb_update_o pulses", dtlb_upd_cnt - base_d, n_d);
  check_val("ptw_error_o pulses", err_cnt - base_e, n_e);
endtask

// miss pulse is checked mid-cycle and the access drops after one clock
task automatic run_walk(input logic instr, input logic [38:0] va, input logic store);
  mark_counts();
  @(negedge clk_i);
  if (instr) begin
    itlb_access_i = 1'b1;
    itlb_vaddr_i  = va;
  end else begin
    dtlb_access_i  = 1'b1;
    dtlb_vaddr_i   = va;
    lsu_is_store_i = store;
  end
  #1;
  check_val(instr ? "itlb_miss_o" : "dtlb_miss_o", instr ? itlb_miss_o : dtlb_miss_o, 1);
  @(negedge clk_i);
  itlb_access_i  = 1'b0;
  dtlb_access_i  = 1'b0;
  lsu_is_store_i = 1'b0;
  wait_walk_end();
  // walk side stays visible after the walk
  check_val("walking_instr_o", walking_instr_o, instr);
endtask

task automatic check_leaf(input logic [38:0] va, input logic [63:0] pte, input logic g1,
                          input logic m2);
  check_val("update.vpn", last_upd.vpn, va[38:12]);
  check_val("update.asid", last_upd.asid, asid_i);
  check_val("update.content", last_upd.content, pte);
  check_val("update.is_1g", last_upd.is_1g, g1);
  check_val("update.is_2m", last_upd.is_2m, m2);
  check_val("update_vaddr_o", update_vaddr_o, va);
endtask

task automatic test_instr_4k();
  logic [38:0] va;
  logic [63:0] leaf;
  va   = 39'h4a_b3c5_d000;
  leaf = pte_word(44'h0_0123_4567, F_V | F_R | F_X | F_A);
  pt_mem.delete();
  addr_log.delete();
  build_3level(va, 44'h0_0000_0201, 44'h0_0000_0302, leaf);
  run_walk(1'b1, va, 1'b0);
  expect_outcome(1, 0, 0);
  check_leaf(va, leaf, 1'b0, 1'b0);
  check_val("mem_addr_o count", addr_log.size(), 3);
  check_val("mem_addr_o lvl1", addr_log[0], pte_addr(satp_ppn_i, va[38:30]));
  check_val("mem_addr_o lvl2", addr_log[1], pte_addr(44'h0_0000_0201, va[29:21]));
  check_val("mem_addr_o lvl3", addr_log[2], pte_addr(44'h0_0000_0302, va[20:12]));
endtask

task automatic test_data_1g();
  logic [38:0] va;
  logic [63:0] leaf;
  va   = 39'h15_4321_0000;
  leaf = pte_word(44'h0_0004_0000, F_V | F_R | F_A);
  pt_mem.delete();
  pt_mem[pte_addr(satp_ppn_i, va[38:30])] = leaf;
  run_walk(1'b0, va, 1'b0);
  expect_outcome(0, 1, 0);
  check_leaf(va, leaf, 1'b1, 1'b0);
  // misaligned superpage
  pt_mem[pte_addr(satp_ppn_i, va[38:30])] = pte_word(44'h0_0004_0001, F_V | F_R | F_A);
  run_walk(1'b0, va, 1'b0);
  expect_outcome(0, 0, 1);
endtask

task automatic test_invalid_pte();
  logic [38:0] va;
  va = 39'h33_0000_7000;
  pt_mem.delete();
  pt_mem[pte_addr(satp_ppn_i, va[38:30])] = pte_word(44'h0_0004_0000, F_R | F_A);
  run_walk(1'b0, va, 1'b0);
  expect_outcome(0, 0, 1);
  pt_mem[pte_addr(satp_ppn_i, va[38:30])] = pte_word(44'h0_0004_0000, F_V | F_W | F_A);
  run_walk(1'b0, va, 1'b0);
  expect_outcome(0, 0, 1);
  // pointer found at the last level
  build_3level(va, 44'h0_0000_0411, 44'h0_0000_0522, pte_word(44'h0_0000_0633, F_V));
  run_walk(1'b0, va, 1'b0);
  expect_outcome(0, 0, 1);
endtask

task automatic test_store_dirty();
  logic [38:0] va;
  logic [63:0] leaf;
  va = 39'h0f_0f0f_1000;
  pt_mem.delete();
  build_3level(va, 44'h0_0000_0711, 44'h0_0000_0822,
               pte_word(44'h0_0000_0abc, F_V | F_R | F_W | F_A));
  run_walk(1'b0, va, 1'b1);
  expect_outcome(0, 0, 1);
  leaf = pte_word(44'h0_0000_0abc, F_V | F_R | F_W | F_A | F_D);
  pt_mem[pte_addr(44'h0_0000_0822, va[20:12])] = leaf;
  run_walk(1'b0, va, 1'b1);
  expect_outcome(0, 1, 0);
  check_leaf(va, leaf, 1'b0, 1'b0);
endtask

task automatic test_dual_miss();
  logic [38:0] va;
  int          im0;
  int          dm0;
  va  = 39'h21_2345_6000;
  im0 = itlb_miss_cnt;
  dm0 = dtlb_miss_cnt;
  pt_mem.delete();
  build_3level(va, 44'h0_0000_0911, 44'h0_0000_0a22,
               pte_word(44'h0_0000_0bcd, F_V | F_R | F_X | F_A));
  mark_counts();
  @(negedge clk_i);
  itlb_access_i = 1'b1;
  itlb_vaddr_i  = va;
  dtlb_access_i = 1'b1;
  dtlb_vaddr_i  = va;
  #1;
  check_val("dtlb_miss_o", dtlb_miss_o, 1);
  check_val("itlb_miss_o", itlb_miss_o, 0);
  @(negedge clk_i);
  dtlb_access_i = 1'b0;
  wait_walk_end();
  expect_outcome(0, 1, 0);
  // held instruction miss is taken once the walker is free
  mark_counts();
  while (!(ptw_active_o && walking_instr_o)) @(negedge clk_i);
  itlb_access_i = 1'b0;
  wait_walk_end();
  expect_outcome(1, 0, 0);
  check_val("itlb_miss_o pulses", itlb_miss_cnt - im0, 1);
  check_val("dtlb_miss_o pulses", dtlb_miss_cnt - dm0, 1);
endtask

task automatic test_flush_drain();
  logic [38:0] va;
  logic [63:0] leaf;
  va   = 39'h4a_b3c5_d000;
  leaf = pte_word(44'h0_0123_4567, F_V | F_R | F_X | F_A);
  pt_mem.delete();
  build_3level(va, 44'h0_0000_0201, 44'h0_0000_0302, leaf);
  mark_counts();
  @(negedge clk_i);
  itlb_access_i = 1'b1;
  itlb_vaddr_i  = va;
  @(negedge clk_i);
  itlb_access_i = 1'b0;
  while (!mem_gnt_i) @(posedge clk_i);
  @(negedge clk_i);
  flush_i = 1'b1;
  @(negedge clk_i);
  flush_i = 1'b0;
  while (ptw_active_o) @(negedge clk_i);
  check_val("response outstanding at ptw_active_o fall", rsp_wait, 0);
  repeat (2) @(negedge clk_i);
  expect_outcome(0, 0, 0);
  run_walk(1'b1, va, 1'b0);
  expect_outcome(1, 0, 0);
  check_leaf(va, leaf, 1'b0, 1'b0);
endtask

`endif

/* verif/ptw_tb.sv */
// --------------------
// sv39 page-table walker testbench
// clock, reset, PTE memory model, walk monitor and test sequence
// --------------------

`timescale 1ns/10ps

`include "ptw_settings.svh"

module ptw_tb;

  // twelve walks, three levels each, eight cycles per level, doubled
  localparam int WALKS       = 12;
  localparam int CYCLE_LIMIT = WALKS * 3 * 8 * 2;

  // PTE flag bits, v in bit 0 up to d in bit 7
  localparam logic [7:0] F_V = 8'h01;
  localparam logic [7:0] F_R = 8'h02;
  localparam logic [7:0] F_W = 8'h04;
  localparam logic [7:0] F_X = 8'h08;
  localparam logic [7:0] F_A = 8'h40;
  localparam logic [7:0] F_D = 8'h80;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  flush_i;
  logic                  itlb_access_i;
  logic                  itlb_hit_i;
  logic [`PTW_VLEN-1:0]  itlb_vaddr_i;
  logic                  dtlb_access_i;
  logic                  dtlb_hit_i;
  logic [`PTW_VLEN-1:0]  dtlb_vaddr_i;
  logic                  lsu_is_store_i;
  logic                  en_translation_i;
  logic                  en_ld_st_translation_i;
  logic [`PTW_ASIDW-1:0] asid_i;
  logic [`PTW_PPNW-1:0]  satp_ppn_i;
  logic                  itlb_miss_o;
  logic                  dtlb_miss_o;
  logic                  mem_req_o;
  logic [`PTW_PLEN-1:0]  mem_addr_o;
  logic                  mem_gnt_i;
  logic                  mem_rvalid_i;
  logic [`PTW_PTEW-1:0]  mem_rdata_i;
  logic                  ptw_active_o;
  logic                  walking_instr_o;
  logic                  ptw_error_o;
  logic [`PTW_VLEN-1:0]  update_vaddr_o;
  ptw_pkg::tlb_update_t  itlb_update_o;
  ptw_pkg::tlb_update_t  dtlb_update_o;

  // --------------------
  // memory model state
  // --------------------
  logic [`PTW_PTEW-1:0] pt_mem [logic [`PTW_PLEN-1:0]];
  // every granted address, in order
  logic [`PTW_PLEN-1:0] addr_log [$];
  integer               seed;
  int                   gnt_wait;
  int                   rsp_wait;
  logic [`PTW_PTEW-1:0] rsp_data;

  // monitor counters
  int                   cycle_cnt;
  int                   itlb_upd_cnt;
  int                   dtlb_upd_cnt;
  int                   err_cnt;
  int                   itlb_miss_cnt;
  int                   dtlb_miss_cnt;
  ptw_pkg::tlb_update_t last_upd;

  sv39_ptw_top dut (
    .clk_i                  (clk_i),
    .arst_n_i               (arst_n_i),
    .flush_i                (flush_i),
    .itlb_access_i          (itlb_access_i),
    .itlb_hit_i             (itlb_hit_i),
    .itlb_vaddr_i           (itlb_vaddr_i),
    .dtlb_access_i          (dtlb_access_i),
    .dtlb_hit_i             (dtlb_hit_i),
    .dtlb_vaddr_i           (dtlb_vaddr_i),
    .lsu_is_store_i         (lsu_is_store_i),
    .en_translation_i       (en_translation_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .asid_i                 (asid_i),
    .satp_ppn_i             (satp_ppn_i),
    .itlb_miss_o            (itlb_miss_o),
    .dtlb_miss_o            (dtlb_miss_o),
    .mem_req_o              (mem_req_o),
    .mem_addr_o             (mem_addr_o),
    .mem_gnt_i              (mem_gnt_i),
    .mem_rvalid_i           (mem_rvalid_i),
    .mem_rdata_i            (mem_rdata_i),
    .ptw_active_o           (ptw_active_o),
    .walking_instr_o        (walking_instr_o),
    .ptw_error_o            (ptw_error_o),
    .update_vaddr_o         (update_vaddr_o),
    .itlb_update_o          (itlb_update_o),
    .dtlb_update_o          (dtlb_update_o)
  );

  `include "ptw_tb_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------
  // PTE memory, driven on the falling edge
  // --------------------
  // grant after 0..3 cycles, response 1..3 cycles after the grant
  always @(negedge clk_i) begin
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    if (rsp_wait > 0) begin
      rsp_wait = rsp_wait - 1;
      if (rsp_wait == 0) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = rsp_data;
      end
    end
    if (!mem_req_o || !arst_n_i) begin
      gnt_wait = -1;
    end else if (rsp_wait == 0) begin
      if (gnt_wait < 0) begin
        gnt_wait = rand_below(4);
      end
      if (gnt_wait == 0) begin
        mem_gnt_i = 1'b1;
        addr_log.push_back(mem_addr_o);
        // unmapped addresses read as an invalid PTE
        rsp_data  = pt_mem.exists(mem_addr_o) ? pt_mem[mem_addr_o] : 64'h0;
        rsp_wait  = 1 + rand_below(3);
        gnt_wait  = -1;
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

  // --------------------
  // pulse monitor and timeout
  // --------------------
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      cycle_cnt = cycle_cnt + 1;
      if (itlb_update_o.valid) begin
        itlb_upd_cnt = itlb_upd_cnt + 1;
        last_upd     = itlb_update_o;
      end
      if (dtlb_update_o.valid) begin
        dtlb_upd_cnt = dtlb_upd_cnt + 1;
        last_upd     = dtlb_update_o;
      end
      if (ptw_error_o) err_cnt = err_cnt + 1;
      if (itlb_miss_o) itlb_miss_cnt = itlb_miss_cnt + 1;
      if (dtlb_miss_o) dtlb_miss_cnt = dtlb_miss_cnt + 1;
      if (cycle_cnt > CYCLE_LIMIT) begin
        $display("timeout: walks did not finish within %0d cycles", CYCLE_LIMIT);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped by timeout");
      end
    end
  end

  // --------------------
  // test sequence
  // --------------------
  initial begin
    seed                   = 99982;
    gnt_wait               = -1;
    rsp_wait               = 0;
    rsp_data               = '0;
    cycle_cnt              = 0;
    itlb_upd_cnt           = 0;
    dtlb_upd_cnt           = 0;
    err_cnt                = 0;
    itlb_miss_cnt          = 0;
    dtlb_miss_cnt          = 0;
    last_upd               = '0;
    arst_n_i               = 1'b0;
    flush_i                = 1'b0;
    itlb_access_i          = 1'b0;
    itlb_hit_i             = 1'b0;
    itlb_vaddr_i           = '0;
    dtlb_access_i          = 1'b0;
    dtlb_hit_i             = 1'b0;
    dtlb_vaddr_i           = '0;
    lsu_is_store_i         = 1'b0;
    en_translation_i       = 1'b1;
    en_ld_st_translation_i = 1'b1;
    asid_i                 = 16'h5a3c;
    satp_ppn_i             = 44'h0_0008_0001;
    mem_gnt_i              = 1'b0;
    mem_rvalid_i           = 1'b0;
    mem_rdata_i            = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    check_reset_outputs();
    test_instr_4k();
    test_data_1g();
    test_invalid_pte();
    test_store_dirty();
    test_dual_miss();
    test_flush_drain();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* src/sv39_ptw_top.sv */
// --------------------
// sv39 page-table walker top
// miss arbiter, walk FSM and PTE checker with plain ports
// --------------------

`timescale 1ns/10ps

`include "ptw_settings.svh"

module sv39_ptw_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  // tlb lookups
  input  logic                  itlb_access_i,
  input  logic                  itlb_hit_i,
  input  logic [`PTW_VLEN-1:0]  itlb_vaddr_i,
  input  logic                  dtlb_access_i,
  input  logic                  dtlb_hit_i,
  input  logic [`PTW_VLEN-1:0]  dtlb_vaddr_i,
  input  logic                  lsu_is_store_i,
  // csr context
  input  logic                  en_translation_i,
  input  logic                  en_ld_st_translation_i,
  input  logic [`PTW_ASIDW-1:0] asid_i,
  input  logic [`PTW_PPNW-1:0]  satp_ppn_i,
  output logic                  itlb_miss_o,
  output logic                  dtlb_miss_o,
  // PTE read port
  output logic                  mem_req_o,
  output logic [`PTW_PLEN-1:0]  mem_addr_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  logic [`PTW_PTEW-1:0]  mem_rdata_i,
  // walk status and refills
  output logic                  ptw_active_o,
  output logic                  walking_instr_o,
  output logic                  ptw_error_o,
  output logic [`PTW_VLEN-1:0]  update_vaddr_o,
  output ptw_pkg::tlb_update_t  itlb_update_o,
  output ptw_pkg::tlb_update_t  dtlb_update_o
);

  walk_req_if walk_req ();
  pte_chk_if  pte_chk ();

  ptw_miss_arbiter u_arbiter (
    .clk_i                  (clk_i),
    .arst_n_i               (arst_n_i),
    .itlb_access_i          (itlb_access_i),
    .itlb_hit_i             (itlb_hit_i),
    .itlb_vaddr_i           (itlb_vaddr_i),
    .dtlb_access_i          (dtlb_access_i),
    .dtlb_hit_i             (dtlb_hit_i),
    .dtlb_vaddr_i           (dtlb_vaddr_i),
    .lsu_is_store_i         (lsu_is_store_i),
    .en_translation_i       (en_translation_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .asid_i                 (asid_i),
    .satp_ppn_i             (satp_ppn_i),
    .itlb_miss_o            (itlb_miss_o),
    .dtlb_miss_o            (dtlb_miss_o),
    .req                    (walk_req.arbiter)
  );

  ptw_walker u_walker (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .flush_i         (flush_i),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_gnt_i       (mem_gnt_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .ptw_active_o    (ptw_active_o),
    .walking_instr_o (walking_instr_o),
    .ptw_error_o     (ptw_error_o),
    .update_vaddr_o  (update_vaddr_o),
    .req             (walk_req.walker),
    .chk             (pte_chk.walker)
  );

  ptw_pte_check u_pte_check (
    .chk (pte_chk.check)
  );

  // one refill record steered to the side that owns the walk
  always_comb begin
    itlb_update_o       = pte_chk.update;
    itlb_update_o.valid = pte_chk.update.valid & pte_chk.is_instr;
    dtlb_update_o       = pte_chk.update;
    dtlb_update_o.valid = pte_chk.update.valid & ~pte_chk.is_instr;
  end

endmodule

/* src/ptw_pte_check.sv */
// --------------------
// sv39 PTE checker
// classifies a PTE as pointer, good leaf or fault and forms the
// TLB refill record
// --------------------

`timescale 1ns/10ps

module ptw_pte_check (
  pte_chk_if.check chk
);

  logic pte_bad;
  logic is_pointer;
  logic ptr_bad;
  logic perm_bad;
  logic misaligned;

  // --------------------
  // classification
  // --------------------
  // invalid entry, write-only encoding or reserved bits in use
  assign pte_bad = ~chk.pte.v | (chk.pte.w & ~chk.pte.r) | (|chk.pte.reserved);

  // neither readable nor executable means next-level table
  assign is_pointer = ~chk.pte.r & ~chk.pte.x;

  // no table below LVL3, and a/d/u are reserved on pointers
  assign ptr_bad = (chk.lvl == ptw_pkg::LVL3) | chk.pte.a | chk.pte.d | chk.pte.u;

  // leaf permissions
  // accessed bit is software managed, so a clear a always faults
  always_comb begin
    perm_bad = 1'b0;
    if (chk.is_instr) begin
      if (!chk.pte.x || !chk.pte.a) begin
        perm_bad = 1'b1;
      end
    end else begin
      if (!chk.pte.a || (!chk.pte.r && !chk.pte.x)) begin
        perm_bad = 1'b1;
      end
    end
    // stores also need write permission and a set dirty bit
    if (chk.is_store && (!chk.pte.w || !chk.pte.d)) begin
      perm_bad = 1'b1;
    end
  end

  // superpage ppn must be aligned to its own size
  assign misaligned = ((chk.lvl == ptw_pkg::LVL1) && (chk.pte.ppn[17:0] != '0)) ||
                      ((chk.lvl == ptw_pkg::LVL2) && (chk.pte.ppn[8:0] != '0));

  always_comb begin
    if (pte_bad) begin
      chk.verdict = ptw_pkg::FAULT;
    end else if (is_pointer) begin
      chk.verdict = ptr_bad ? ptw_pkg::FAULT : ptw_pkg::NEXT_LEVEL;
    end else if (perm_bad || misaligned) begin
      chk.verdict = ptw_pkg::FAULT;
    end else begin
      chk.verdict = ptw_pkg::LEAF_OK;
    end
  end

  // --------------------
  // TLB refill record
  // --------------------
  always_comb begin
    // valid only in the walker's judging cycle
    chk.update.valid   = chk.pte_valid & (chk.verdict == ptw_pkg::LEAF_OK);
    chk.update.vpn     = chk.vaddr[38:12];
    chk.update.asid    = chk.asid;
    chk.update.is_1g   = (chk.lvl == ptw_pkg::LVL1);
    chk.update.is_2m   = (chk.lvl == ptw_pkg::LVL2);
    // content is the PTE as read
    chk.update.content = chk.pte;
  end

endmodule

/* src/ptw_walker.sv */
// --------------------
// sv39 walk FSM
// drives the PTE read port, registers the response and follows
// the checker verdict through up to three levels
// --------------------

`timescale 1ns/10ps

`include "ptw_settings.svh"

module ptw_walker (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 flush_i,
  // PTE read port
  output logic                 mem_req_o,
  output logic [`PTW_PLEN-1:0] mem_addr_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  logic [`PTW_PTEW-1:0] mem_rdata_i,
  // status
  output logic                 ptw_active_o,
  output logic                 walking_instr_o,
  output logic                 ptw_error_o,
  output logic [`PTW_VLEN-1:0] update_vaddr_o,
  walk_req_if.walker           req,
  pte_chk_if.walker            chk
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    PROPAGATE_ERROR,
    WAIT_RVALID
  } state_e;

  state_e                state_q, state_d;
  ptw_pkg::ptw_lvl_e     lvl_q, lvl_d;
  ptw_pkg::ptw_lvl_e     lvl_nxt;
  logic                  is_instr_q, is_instr_d;
  logic                  is_store_q, is_store_d;
  logic [`PTW_VLEN-1:0]  vaddr_q, vaddr_d;
  logic [`PTW_ASIDW-1:0] asid_q, asid_d;
  // byte address of the PTE being fetched
  logic [`PTW_PLEN-1:0]  pptr_q, pptr_d;
  // response buffer stage
  logic                  rvalid_q;
  ptw_pkg::pte_t         rdata_q;

  // vpn segment indexing the table at a given level
  function automatic logic [`PTW_VPN_SEGW-1:0] vpn_seg(
    input logic [`PTW_VLEN-1:0] va,
    input ptw_pkg::ptw_lvl_e    lvl
  );
    int lsb;
    lsb = `PTW_PGOFFW + `PTW_VPN_SEGW * (`PTW_LEVELS - 1 - int'(lvl));
    return va[lsb +: `PTW_VPN_SEGW];
  endfunction

  // --------------------
  // outputs
  // --------------------
  assign mem_req_o       = (state_q == WAIT_GRANT);
  assign mem_addr_o      = pptr_q;
  assign ptw_active_o    = (state_q != IDLE);
  assign walking_instr_o = is_instr_q;
  assign ptw_error_o     = (state_q == PROPAGATE_ERROR);
  assign update_vaddr_o  = vaddr_q;
  // no new walk is accepted while a flush is on
  assign req.idle        = (state_q == IDLE) & ~flush_i;

  // checker sees the buffered PTE with the walk context
  assign chk.pte       = rdata_q;
  assign chk.lvl       = lvl_q;
  assign chk.is_instr  = is_instr_q;
  assign chk.is_store  = is_store_q;
  assign chk.vaddr     = vaddr_q;
  assign chk.asid      = asid_q;
  // judging cycle, a flush suppresses any update
  assign chk.pte_valid = (state_q == PTE_LOOKUP) & rvalid_q & ~flush_i;

  // pointers only ever step one level down
  assign lvl_nxt = (lvl_q == ptw_pkg::LVL1) ? ptw_pkg::LVL2 : ptw_pkg::LVL3;

  // --------------------
  // next state
  // --------------------
  always_comb begin
    state_d    = state_q;
    lvl_d      = lvl_q;
    is_instr_d = is_instr_q;
    is_store_d = is_store_q;
    vaddr_d    = vaddr_q;
    asid_d     = asid_q;
    pptr_d     = pptr_q;

    case (state_q)
      IDLE: begin
        // capture the whole request in the start cycle
        if (req.start) begin
          state_d    = WAIT_GRANT;
          lvl_d      = ptw_pkg::LVL1;
          is_instr_d = req.is_instr;
          is_store_d = req.is_store;
          vaddr_d    = req.vaddr;
          asid_d     = req.asid;
          pptr_d     = {req.root_ppn, vpn_seg(req.vaddr, ptw_pkg::LVL1),
                        {`PTW_PTESIZE_LOG2{1'b0}}};
        end
      end
      WAIT_GRANT: begin
        // request and address hold until granted
        if (mem_gnt_i) begin
          state_d = PTE_LOOKUP;
        end
      end
      PTE_LOOKUP: begin
        // buffered response is judged here
        if (rvalid_q) begin
          case (chk.verdict)
            ptw_pkg::NEXT_LEVEL: begin
              state_d = WAIT_GRANT;
              lvl_d   = lvl_nxt;
              pptr_d  = {rdata_q.ppn, vpn_seg(vaddr_q, lvl_nxt),
                         {`PTW_PTESIZE_LOG2{1'b0}}};
            end
            // checker already raised the update this cycle
            ptw_pkg::LEAF_OK: state_d = IDLE;
            default: state_d = PROPAGATE_ERROR;
          endcase
        end
      end
      // error pulse is this single cycle
      PROPAGATE_ERROR: state_d = IDLE;
      // swallow the response of an aborted walk
      WAIT_RVALID: begin
        if (rvalid_q) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // --------------------
    // flush
    // --------------------
    // a granted request still owes its response, so drain it first
    if (flush_i) begin
      if ((state_q == WAIT_GRANT && mem_gnt_i) ||
          (state_q == PTE_LOOKUP && !rvalid_q) ||
          (state_q == WAIT_RVALID && !rvalid_q)) begin
        state_d = WAIT_RVALID;
      end else begin
        state_d = IDLE;
      end
    end
  end

  // control flops
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IDLE;
      lvl_q      <= ptw_pkg::LVL1;
      is_instr_q <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      state_q    <= state_d;
      lvl_q      <= lvl_d;
      is_instr_q <= is_instr_d;
      rvalid_q   <= mem_rvalid_i;
    end
  end

  // walk context and response payload
  always_ff @(posedge clk_i) begin
    is_store_q <= is_store_d;
    vaddr_q    <= vaddr_d;
    asid_q     <= asid_d;
    pptr_q     <= pptr_d;
    if (mem_rvalid_i) begin
      rdata_q <= ptw_pkg::pte_t'(mem_rdata_i);
    end
  end

  // --------------------
  // assertions
  // --------------------
  // address may not move while the port waits for a grant
  a_addr_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o && !mem_gnt_i |=> $stable(mem_addr_o)
  );

  // checker never asks for a level below LVL3
  a_no_level_past_lvl3: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (state_q == PTE_LOOKUP && rvalid_q && lvl_q == ptw_pkg::LVL3)
      |-> chk.verdict != ptw_pkg::NEXT_LEVEL
  );

endmodule

/* src/ptw_miss_arbiter.sv */
// --------------------
// TLB miss arbiter
// picks the itlb or dtlb miss and issues the walk request
// --------------------

`timescale 1ns/10ps

`include "ptw_settings.svh"

module ptw_miss_arbiter (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // instruction side lookup
  input  logic                  itlb_access_i,
  input  logic                  itlb_hit_i,
  input  logic [`PTW_VLEN-1:0]  itlb_vaddr_i,
  // data side lookup
  input  logic                  dtlb_access_i,
  input  logic                  dtlb_hit_i,
  input  logic [`PTW_VLEN-1:0]  dtlb_vaddr_i,
  input  logic                  lsu_is_store_i,
  // csr context
  input  logic                  en_translation_i,
  input  logic                  en_ld_st_translation_i,
  input  logic [`PTW_ASIDW-1:0] asid_i,
  input  logic [`PTW_PPNW-1:0]  satp_ppn_i,
  // performance counter pulses
  output logic                  itlb_miss_o,
  output logic                  dtlb_miss_o,
  walk_req_if.arbiter           req
);

  logic dtlb_miss_raw;
  logic itlb_miss_raw;

  // --------------------
  // miss detection
  // --------------------
  // a translated lookup that missed
  assign dtlb_miss_raw = en_ld_st_translation_i & dtlb_access_i & ~dtlb_hit_i;
  // instruction side yields whenever the lsu is using the dtlb
  assign itlb_miss_raw = en_translation_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;

  // misses only count when the walker can take them
  assign dtlb_miss_o = req.idle & dtlb_miss_raw;
  assign itlb_miss_o = req.idle & itlb_miss_raw;

  // --------------------
  // walk request
  // --------------------
  assign req.start    = itlb_miss_o | dtlb_miss_o;
  assign req.is_instr = ~dtlb_miss_raw;
  assign req.vaddr    = dtlb_miss_raw ? dtlb_vaddr_i : itlb_vaddr_i;
  // stores only come from the lsu
  assign req.is_store = dtlb_miss_raw & lsu_is_store_i;
  assign req.asid     = asid_i;
  // walk always starts at the satp root table
  assign req.root_ppn = satp_ppn_i;

  // the walker leaves idle on the clock after it takes a start
  a_start_accepted: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req.start |=> !req.idle
  );

endmodule

/* src/ptw_if.sv */
// --------------------
// walker internal bundles
// walk request from the miss arbiter and PTE check path
// --------------------

`timescale 1ns/10ps

`include "ptw_settings.svh"

// start is a single-cycle pulse that is only legal while idle is high
interface walk_req_if;
  logic                  start;
  logic                  is_instr;
  logic [`PTW_VLEN-1:0]  vaddr;
  logic [`PTW_ASIDW-1:0] asid;
  logic [`PTW_PPNW-1:0]  root_ppn;
  logic                  is_store;
  // walker ready for a new walk
  logic                  idle;

  modport arbiter (output start, is_instr, vaddr, asid, root_ppn, is_store, input idle);
  modport walker (input start, is_instr, vaddr, asid, root_ppn, is_store, output idle);
endinterface

// walker presents the registered PTE with its walk context
// checker answers combinationally in the same cycle
interface pte_chk_if;
  ptw_pkg::pte_t         pte;
  ptw_pkg::ptw_lvl_e     lvl;
  // high in the one cycle the walker acts on the verdict
  logic                  pte_valid;
  logic                  is_instr;
  logic                  is_store;
  logic [`PTW_VLEN-1:0]  vaddr;
  logic [`PTW_ASIDW-1:0] asid;
  ptw_pkg::pte_verdict_e verdict;
  ptw_pkg::tlb_update_t  update;

  modport walker (output pte, lvl, pte_valid, is_instr, is_store, vaddr, asid,
                  input verdict, update);
  modport check (input pte, lvl, pte_valid, is_instr, is_store, vaddr, asid,
                 output verdict, update);
endinterface

/* src/ptw_pkg.sv */
// --------------------
// sv39 page-table walker types
// PTE layout, walk level, checker verdict and TLB update record
// --------------------

`include "ptw_settings.svh"

package ptw_pkg;

  // --------------------
  // page table entry
  // --------------------
  // msb first so a raw 64-bit read casts straight onto it
  typedef struct packed {
    logic [9:0]           reserved;
    logic [`PTW_PPNW-1:0] ppn;
    logic [1:0]           rsw;
    logic                 d;
    logic                 a;
    logic                 g;
    logic                 u;
    logic                 x;
    logic                 w;
    logic                 r;
    logic                 v;
  } pte_t;

  // table level being looked up
  // LVL1 maps 1G, LVL2 maps 2M, LVL3 maps 4K
  typedef enum logic [1:0] {
    LVL1,
    LVL2,
    LVL3
  } ptw_lvl_e;

  // --------------------
  // TLB refill record
  // --------------------
  typedef struct packed {
    logic                                      valid;
    logic [`PTW_VLEN-`PTW_PGOFFW-1:0]          vpn;
    logic [`PTW_ASIDW-1:0]                     asid;
    logic                                      is_2m;
    logic                                      is_1g;
    pte_t                                      content;
  } tlb_update_t;

  // outcome of judging one PTE
  typedef enum logic [1:0] {
    NEXT_LEVEL,
    LEAF_OK,
    FAULT
  } pte_verdict_e;

endpackage

/* src/ptw_settings.svh */
// --------------------
// sv39 page-table walker widths
// address, page number and level constants shared by all blocks
// --------------------

`ifndef PTW_SETTINGS_SVH
`define PTW_SETTINGS_SVH

// virtual address width for sv39
`define PTW_VLEN 39

// physical address width
`define PTW_PLEN 56

// physical page number width
`define PTW_PPNW 44

// address space identifier width
`define PTW_ASIDW 16

// one PTE is 8 bytes
`define PTW_PTESIZE_LOG2 3
`define PTW_PTEW 64

// page offset bits and one VPN segment per table level
`define PTW_PGOFFW 12
`define PTW_VPN_SEGW 9
`define PTW_LEVELS 3

`endif
